// File: source/axi_perf_pkg.sv
`default_nettype none

package axi_perf_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  localparam int AXI_ADDR_WIDTH = 20;
  localparam int AXI_DATA_WIDTH = 16;
  localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
  localparam int AXI_ID_WIDTH   = 4;

  typedef logic [AXI_ADDR_WIDTH-1:0] addr_t;
  typedef logic [AXI_DATA_WIDTH-1:0] data_t;
  typedef logic [AXI_STRB_WIDTH-1:0] strb_t;
  typedef logic [AXI_ID_WIDTH-1:0]   id_t;
  // beats minus one, as on awlen
  typedef logic [7:0]                axlen_t;
  typedef logic [15:0]               burst_cnt_t;
  typedef logic [1:0]                resp_t;
  typedef logic [31:0]               stat_t;

  // 2-byte beats
  localparam logic [2:0] AXI_SIZE_FULL  = 3'd1;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam resp_t      RESP_OKAY      = 2'b00;
  localparam resp_t      RESP_SLVERR    = 2'b10;

  // --------------------------------------------------
  // payloads
  // --------------------------------------------------
  typedef struct packed {
    addr_t      base;
    axlen_t     beats_m1;
    addr_t      stride;
    burst_cnt_t num_bursts;
  } perf_cfg_t;

  typedef struct packed {
    id_t        id;
    addr_t      addr;
    axlen_t     len;
    logic [2:0] size;
    logic [1:0] burst;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    stat_t bursts;
    stat_t beats;
    stat_t errors;
    stat_t cycles;
  } perf_stats_t;

  typedef enum logic [1:0] {
    GEN_IDLE,
    GEN_ISSUE,
    GEN_DRAIN,
    GEN_DONE
  } gen_state_t;

endpackage

`default_nettype wire

// File: source/perf_burst_gen.sv
`timescale 1ns/1ps
`default_nettype none

module perf_burst_gen
  import axi_perf_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_start,
  input  perf_cfg_t  i_cfg,
  input  logic       i_awready,
  input  logic       i_bvalid,
  input  b_chan_t    i_b,
  input  logic       i_fifo_full,
  output logic       o_busy,
  output logic       o_start_run,
  output logic       o_awvalid,
  output aw_chan_t   o_aw,
  output logic       o_bready,
  output logic       o_push,
  output axlen_t     o_push_len
);

  gen_state_t state;
  gen_state_t state_next;
  perf_cfg_t  cfg;
  addr_t      addr;
  burst_cnt_t issued;
  burst_cnt_t resp_cnt;
  burst_cnt_t resp_next;
  logic       aw_fire;
  logic       b_fire;

  assign o_busy      = (state == GEN_ISSUE) || (state == GEN_DRAIN);
  assign o_start_run = i_start && !o_busy;
  // full fifo can only clear while waiting, so valid stays stable
  assign o_awvalid   = (state == GEN_ISSUE) && !i_fifo_full;
  assign o_bready    = o_busy;

  assign aw_fire   = o_awvalid && i_awready;
  // only id zero is ever issued
  assign b_fire    = i_bvalid && o_bready && (i_b.id == '0);
  assign resp_next = resp_cnt + burst_cnt_t'(b_fire);

  assign o_aw = '{id: '0, addr: addr, len: cfg.beats_m1,
                  size: AXI_SIZE_FULL, burst: AXI_BURST_INCR};

  assign o_push     = aw_fire;
  assign o_push_len = cfg.beats_m1;

  always_comb begin
    state_next = state;
    case (state)
      GEN_IDLE, GEN_DONE: begin
        if (i_start) begin
          state_next = (i_cfg.num_bursts == '0) ? GEN_DRAIN : GEN_ISSUE;
        end
      end
      GEN_ISSUE: begin
        if (aw_fire && (issued == cfg.num_bursts - 1'b1)) begin
          state_next = GEN_DRAIN;
        end
      end
      GEN_DRAIN: begin
        if (resp_next == cfg.num_bursts) begin
          state_next = GEN_DONE;
        end
      end
      default: state_next = GEN_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= GEN_IDLE;
      issued   <= '0;
      resp_cnt <= '0;
    end else begin
      state <= state_next;
      if (o_start_run) begin
        issued   <= '0;
        resp_cnt <= '0;
      end else begin
        if (aw_fire) begin
          issued <= issued + 1'b1;
        end
        resp_cnt <= resp_next;
      end
    end
  end

  // address walks from base by stride
  always_ff @(posedge clk) begin
    if (o_start_run) begin
      cfg  <= i_cfg;
      addr <= i_cfg.base;
    end else if (aw_fire) begin
      addr <= addr + cfg.stride;
    end
  end

endmodule

`default_nettype wire

// File: source/burst_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module burst_cmd_fifo
  import axi_perf_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   i_push,
  input  axlen_t i_len,
  input  logic   i_pop,
  output logic   o_full,
  output logic   o_cmd_valid,
  output axlen_t o_cmd
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  axlen_t             mem [DEPTH];
  logic   [PTR_W-1:0] wr_ptr;
  logic   [PTR_W-1:0] rd_ptr;
  logic   [CNT_W-1:0] count;
  logic               do_push;
  logic               do_pop;

  assign o_full      = (count == CNT_W'(DEPTH));
  assign o_cmd_valid = (count != '0);
  assign o_cmd       = mem[rd_ptr];

  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && o_cmd_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_len;
    end
  end

endmodule

`default_nettype wire

// File: source/perf_beat_writer.sv
`timescale 1ns/1ps
`default_nettype none

module perf_beat_writer
  import axi_perf_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    i_start_run,
  input  logic    i_cmd_valid,
  input  axlen_t  i_cmd,
  input  logic    i_wready,
  output logic    o_pop,
  output logic    o_wvalid,
  output w_chan_t o_w
);

  // high once the fifo head has been visible for a cycle
  logic   armed;
  axlen_t beat_idx;
  data_t  beat_num;
  logic   last;
  logic   w_fire;

  // --------------------------------------------------
  // data channel
  // --------------------------------------------------
  assign o_wvalid = i_cmd_valid && armed;
  assign last     = (beat_idx == i_cmd);
  assign w_fire   = o_wvalid && i_wready;
  assign o_pop    = w_fire && last;

  assign o_w = '{data: beat_num, strb: '1, last: last};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      armed <= 1'b0;
    end else begin
      armed <= i_cmd_valid;
    end
  end

  // position inside the current burst
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_idx <= '0;
    end else if (i_start_run) begin
      beat_idx <= '0;
    end else if (w_fire) begin
      beat_idx <= last ? '0 : beat_idx + 1'b1;
    end
  end

  // run-wide beat number, forms the data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_num <= '0;
    end else if (i_start_run) begin
      beat_num <= '0;
    end else if (w_fire) begin
      beat_num <= beat_num + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/perf_wr_stats.sv
`timescale 1ns/1ps
`default_nettype none

module perf_wr_stats
  import axi_perf_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_start_run,
  input  logic        i_busy,
  input  logic        i_awvalid,
  input  logic        i_awready,
  input  logic        i_wvalid,
  input  logic        i_wready,
  input  logic        i_bvalid,
  input  logic        i_bready,
  input  resp_t       i_bresp,
  output perf_stats_t o_stats
);

  perf_stats_t stats;
  logic        aw_fire;
  logic        w_fire;
  logic        err_fire;

  assign aw_fire  = i_awvalid && i_awready;
  assign w_fire   = i_wvalid && i_wready;
  assign err_fire = i_bvalid && i_bready && (i_bresp != RESP_OKAY);

  assign o_stats = stats;

  // --------------------------------------------------
  // counters
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stats <= '0;
    end else if (i_start_run) begin
      stats <= '0;
    end else begin
      if (aw_fire) begin
        stats.bursts <= stats.bursts + 1'b1;
      end
      if (w_fire) begin
        stats.beats <= stats.beats + 1'b1;
      end
      if (err_fire) begin
        stats.errors <= stats.errors + 1'b1;
      end
      // busy cycles, for bandwidth
      if (i_busy) begin
        stats.cycles <= stats.cycles + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/axi_perf.sv
`timescale 1ns/1ps
`default_nettype none

module axi_perf
  import axi_perf_pkg::*;
#(
  parameter int CMD_FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_start,
  input  perf_cfg_t   i_cfg,
  output logic        o_busy,
  output perf_stats_t o_stats,
  output logic        o_awvalid,
  output aw_chan_t    o_aw,
  input  logic        i_awready,
  output logic        o_wvalid,
  output w_chan_t     o_w,
  input  logic        i_wready,
  input  logic        i_bvalid,
  input  b_chan_t     i_b,
  output logic        o_bready
);

  logic   start_run;
  logic   fifo_full;
  logic   push;
  axlen_t push_len;
  logic   pop;
  logic   cmd_valid;
  axlen_t cmd;

  // --------------------------------------------------
  // address side
  // --------------------------------------------------
  perf_burst_gen u_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_start    (i_start),
    .i_cfg      (i_cfg),
    .i_awready  (i_awready),
    .i_bvalid   (i_bvalid),
    .i_b        (i_b),
    .i_fifo_full(fifo_full),
    .o_busy     (o_busy),
    .o_start_run(start_run),
    .o_awvalid  (o_awvalid),
    .o_aw       (o_aw),
    .o_bready   (o_bready),
    .o_push     (push),
    .o_push_len (push_len)
  );

  burst_cmd_fifo #(
    .DEPTH(CMD_FIFO_DEPTH)
  ) u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_push     (push),
    .i_len      (push_len),
    .i_pop      (pop),
    .o_full     (fifo_full),
    .o_cmd_valid(cmd_valid),
    .o_cmd      (cmd)
  );

  // --------------------------------------------------
  // data side and counters
  // --------------------------------------------------
  perf_beat_writer u_writer (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_start_run(start_run),
    .i_cmd_valid(cmd_valid),
    .i_cmd      (cmd),
    .i_wready   (i_wready),
    .o_pop      (pop),
    .o_wvalid   (o_wvalid),
    .o_w        (o_w)
  );

  perf_wr_stats u_stats (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_start_run(start_run),
    .i_busy     (o_busy),
    .i_awvalid  (o_awvalid),
    .i_awready  (i_awready),
    .i_wvalid   (o_wvalid),
    .i_wready   (i_wready),
    .i_bvalid   (i_bvalid),
    .i_bready   (o_bready),
    .i_bresp    (i_b.resp),
    .o_stats    (o_stats)
  );

endmodule

`default_nettype wire

// File: test/axi_wr_responder.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_responder
  import axi_perf_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_clear,
  input  logic [31:0] i_err_mask,
  output logic        o_awready,
  input  logic        i_wvalid,
  input  w_chan_t     i_w,
  output logic        o_wready,
  output logic        o_bvalid,
  output b_chan_t     o_b,
  input  logic        i_bready
);

  integer seed;
  // bursts whose last beat arrived but are not answered yet
  int     pending;
  int     resp_idx;
  logic   b_hold;

  initial begin
    seed      = 32'h14d4;
    pending   = 0;
    resp_idx  = 0;
    b_hold    = 1'b0;
    o_awready = 1'b0;
    o_wready  = 1'b0;
    o_bvalid  = 1'b0;
    o_b       = '0;
  end

  always @(posedge clk) begin
    if (!rst_n || i_clear) begin
      pending  = 0;
      resp_idx = 0;
      #1;
      o_awready = 1'b0;
      o_wready  = 1'b0;
      o_bvalid  = 1'b0;
      o_b       = '0;
    end else begin
      if (i_wvalid && o_wready && i_w.last) begin
        pending = pending + 1;
      end
      b_hold = o_bvalid && !i_bready;
      if (o_bvalid && i_bready) begin
        pending  = pending - 1;
        resp_idx = resp_idx + 1;
      end
      #1;
      // address ready 3 of 4 cycles, data ready about half the time
      o_awready = ($random(seed) % 4) != 0;
      o_wready  = ($random(seed) % 2) != 0;
      if (!b_hold) begin
        o_bvalid = (pending > 0) && (($random(seed) % 4) != 0);
        o_b.id   = '0;
        o_b.resp = ((resp_idx < 32) && i_err_mask[resp_idx]) ? RESP_SLVERR : RESP_OKAY;
      end
    end
  end

endmodule

`default_nettype wire

// File: test/axi_perf_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_perf_tb
  import axi_perf_pkg::*;
();

  localparam int NUM_ROWS = 5;

  logic        clk;
  logic        rst_n;
  logic        i_start;
  perf_cfg_t   i_cfg;
  logic        o_busy;
  perf_stats_t o_stats;
  logic        awvalid;
  aw_chan_t    aw;
  logic        awready;
  logic        wvalid;
  w_chan_t     w;
  logic        wready;
  logic        bvalid;
  b_chan_t     b;
  logic        bready;
  logic        resp_clear;
  logic [31:0] err_mask;

  perf_cfg_t   cfg_tab  [NUM_ROWS];
  logic [31:0] mask_tab [NUM_ROWS];

  perf_cfg_t   cur_cfg;
  addr_t       exp_addr;
  int          aw_seen;
  int          w_seen;
  int          b_seen;
  int          cycle_cnt = 0;
  int          timeout_limit;
  int          total_beats;

  axi_perf #(
    .CMD_FIFO_DEPTH(4)
  ) i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_start  (i_start),
    .i_cfg    (i_cfg),
    .o_busy   (o_busy),
    .o_stats  (o_stats),
    .o_awvalid(awvalid),
    .o_aw     (aw),
    .i_awready(awready),
    .o_wvalid (wvalid),
    .o_w      (w),
    .i_wready (wready),
    .i_bvalid (bvalid),
    .i_b      (b),
    .o_bready (bready)
  );

  axi_wr_responder i_resp (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_clear   (resp_clear),
    .i_err_mask(err_mask),
    .o_awready (awready),
    .i_wvalid  (wvalid),
    .i_w       (w),
    .o_wready  (wready),
    .o_bvalid  (bvalid),
    .o_b       (b),
    .i_bready  (bready)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic int beats_in_run(input perf_cfg_t c);
    return int'(c.num_bursts) * (int'(c.beats_m1) + 1);
  endfunction

  function automatic int count_errors(input logic [31:0] mask, input int n);
    int cnt = 0;
    for (int i = 0; (i < 32) && (i < n); i++) begin
      if (mask[i]) begin
        cnt++;
      end
    end
    return cnt;
  endfunction

  task automatic load_table();
    cfg_tab[0]  = '{base: 20'h01000, beats_m1: 8'd3, stride: 20'h00008, num_bursts: 16'd5};
    mask_tab[0] = 32'h0000_0000;
    // single beats, long run, fills the command fifo
    cfg_tab[1]  = '{base: 20'h0fff0, beats_m1: 8'd0, stride: 20'h00002, num_bursts: 16'd40};
    mask_tab[1] = 32'h0000_0421;
    cfg_tab[2]  = '{base: 20'h20000, beats_m1: 8'd7, stride: 20'h00100, num_bursts: 16'd3};
    mask_tab[2] = 32'h0000_0005;
    // address wraps at 20 bits
    cfg_tab[3]  = '{base: 20'hffff8, beats_m1: 8'd1, stride: 20'h00004, num_bursts: 16'd6};
    mask_tab[3] = 32'h0000_003f;
    cfg_tab[4]  = '{base: 20'h00400, beats_m1: 8'd15, stride: 20'h00020, num_bursts: 16'd2};
    mask_tab[4] = 32'h0000_0002;
  endtask

  // --------------------------------------------------
  // bus monitor and timeout
  // --------------------------------------------------
  always @(posedge clk) begin
    if (rst_n && i_start && !o_busy) begin
      cur_cfg  = i_cfg;
      exp_addr = i_cfg.base;
      aw_seen  = 0;
      w_seen   = 0;
      b_seen   = 0;
    end else if (rst_n) begin
      if (awvalid && awready) begin
        if (aw_seen >= int'(cur_cfg.num_bursts)) begin
          stop_on_failure("an address burst was issued beyond the configured count");
        end
        check_value("awaddr", 32'(aw.addr), 32'(exp_addr));
        check_value("awlen", 32'(aw.len), 32'(cur_cfg.beats_m1));
        // size 1 is a 2-byte beat, burst 1 is incrementing
        check_value("awsize", 32'(aw.size), 32'd1);
        check_value("awburst", 32'(aw.burst), 32'd1);
        check_value("awid", 32'(aw.id), 32'd0);
        exp_addr = exp_addr + cur_cfg.stride;
        aw_seen++;
      end
      if (wvalid && wready) begin
        if (w_seen >= beats_in_run(cur_cfg)) begin
          stop_on_failure("a data beat was sent beyond the configured count");
        end
        check_value("wdata", 32'(w.data), 32'(data_t'(w_seen)));
        check_value("wstrb", 32'(w.strb), 32'h3);
        check_value("wlast", 32'(w.last),
                    32'((w_seen % (int'(cur_cfg.beats_m1) + 1)) == int'(cur_cfg.beats_m1)));
        w_seen++;
      end
      if (bvalid && bready) begin
        if (b_seen >= int'(cur_cfg.num_bursts)) begin
          stop_on_failure("more write responses were taken than bursts issued");
        end
        b_seen++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_limit) begin
      stop_on_failure($sformatf("timeout after %0d cycles, the runs did not finish", cycle_cnt));
    end
  end

  task automatic run_row(input perf_cfg_t cfg, input logic [31:0] mask);
    perf_cfg_t other;
    resp_clear = 1'b1;
    err_mask   = mask;
    @(posedge clk);
    #1;
    resp_clear = 1'b0;
    i_cfg      = cfg;
    i_start    = 1'b1;
    @(posedge clk);
    #1;
    i_start = 1'b0;
    check_value("o_busy", 32'(o_busy), 32'd1);
    // a second start while busy must be ignored
    other            = cfg;
    other.base       = ~cfg.base;
    other.num_bursts = cfg.num_bursts + 16'd3;
    i_cfg            = other;
    i_start          = 1'b1;
    @(posedge clk);
    #1;
    i_start = 1'b0;
    i_cfg   = '0;
    while (o_busy) begin
      @(posedge clk);
      #1;
    end
    check_value("responses", 32'(b_seen), 32'(cfg.num_bursts));
    check_value("address bursts", 32'(aw_seen), 32'(cfg.num_bursts));
    check_value("data beats", 32'(w_seen), 32'(beats_in_run(cfg)));
    check_value("o_stats.bursts", o_stats.bursts, 32'(cfg.num_bursts));
    check_value("o_stats.beats", o_stats.beats, 32'(beats_in_run(cfg)));
    check_value("o_stats.errors", o_stats.errors,
                32'(count_errors(mask, int'(cfg.num_bursts))));
    if (o_stats.cycles < 32'(beats_in_run(cfg))) begin
      stop_on_failure("busy cycle count is below the number of beats");
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    i_start    = 1'b0;
    i_cfg      = '0;
    resp_clear = 1'b0;
    err_mask   = '0;
    load_table();
    total_beats = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total_beats += beats_in_run(cfg_tab[r]);
    end
    timeout_limit = total_beats * 20 + 200;
    repeat (3) @(posedge clk);
    #1;
    check_value("o_busy", 32'(o_busy), 32'd0);
    check_value("o_awvalid", 32'(awvalid), 32'd0);
    check_value("o_wvalid", 32'(wvalid), 32'd0);
    check_value("o_bready", 32'(bready), 32'd0);
    rst_n = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(cfg_tab[r], mask_tab[r]);
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
source/axi_perf_pkg.sv
source/perf_burst_gen.sv
source/burst_cmd_fifo.sv
source/perf_beat_writer.sv
source/perf_wr_stats.sv
source/axi_perf.sv
test/axi_wr_responder.sv
test/axi_perf_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module axi_perf_tb \
  -f sources.f -o axi_perf_sim || exit 1

sim_out="$(./obj_dir/axi_perf_sim 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -q "^sim passed$" && exit 0 || exit 1
